/* design/periph_config.svh */
// Widths, counts and memory map of the peripheral subsystem
// Region bases must sit on a (1 << PERIPH_OFS_W) boundary
// Region select is the address bits above the offset field

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus geometry
`define PERIPH_ADDR_W 16
`define PERIPH_DATA_W 32
`define PERIPH_OFS_W 12

// Peripheral sizing
`define PERIPH_NUM_TIMERS 2
`define PERIPH_NUM_SRC 16
`define PERIPH_NUM_EXT_IRQ 8

// Region bases
`define PERIPH_TIMER_BASE 16'h0000
`define PERIPH_IRQC_BASE 16'h1000

// Read data returned with a slave error
`define PERIPH_ERR_RDATA 32'hDEADBEEF

`endif

/* design/periph_bus_pkg.sv */
// Register bus types shared by the decoder, peripherals and response path
// Widths come from the config header

package periph_bus_pkg;

`include "periph_config.svh"

    typedef logic [`PERIPH_ADDR_W-1:0] bus_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] bus_data_t;
    typedef logic [`PERIPH_OFS_W-1:0]  bus_ofs_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Destination picked from the region field
    typedef enum logic [1:0] {
        TGT_TIMER = 2'd0,
        TGT_IRQC  = 2'd1,
        TGT_ERR   = 2'd2
    } bus_target_e;

    typedef enum logic {
        RESP_OKAY   = 1'b0,
        RESP_SLVERR = 1'b1
    } bus_resp_e;

endpackage

/* design/periph_irq_pkg.sv */
// Timer and interrupt controller types, register maps and source indices
// Timer channel n lives at offset n * 0x10 plus its register offset

package periph_irq_pkg;

`include "periph_config.svh"

    typedef logic [`PERIPH_NUM_SRC-1:0]     irq_src_vec_t;
    typedef logic [`PERIPH_NUM_TIMERS-1:0]  timer_irq_t;
    typedef logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq_t;

    // Register offset inside one timer channel
    typedef enum logic [3:0] {
        TREG_CTRL    = 4'h0,
        TREG_COUNT   = 4'h4,
        TREG_COMPARE = 4'h8
    } timer_reg_e;

    typedef enum logic [3:0] {
        IREG_PENDING = 4'h0,
        IREG_ENABLE  = 4'h4,
        IREG_RAW     = 4'h8
    } irqc_reg_e;

    // Source map, source 0 never fires, 11 to 15 reserved
    localparam int SRC_TIMER0 = 1;
    localparam int SRC_TIMER1 = 2;
    localparam int SRC_EXT_LO = 3;

endpackage

/* design/reg_bus_decoder.sv */
// Request stage of the register bus, one request per cycle, no back-pressure
// Exactly one target strobe fires the cycle after a request is sampled
// Regions other than timer and interrupt controller go to the error path

`timescale 1ns/10ps

`include "periph_config.svh"

module reg_bus_decoder (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  periph_bus_pkg::bus_op_e     req_op_i,
    input  periph_bus_pkg::bus_addr_t   req_addr_i,
    input  periph_bus_pkg::bus_data_t   req_wdata_i,
    output logic                        tmr_req_o,
    output logic                        irq_req_o,
    output logic                        err_req_o,
    output periph_bus_pkg::bus_op_e     op_o,
    output periph_bus_pkg::bus_ofs_t    ofs_o,
    output periph_bus_pkg::bus_data_t   wdata_o
);
    import periph_bus_pkg::*;

    localparam int REGION_W = `PERIPH_ADDR_W - `PERIPH_OFS_W;
    localparam logic [REGION_W-1:0] TIMER_REGION =
        REGION_W'(`PERIPH_TIMER_BASE >> `PERIPH_OFS_W);
    localparam logic [REGION_W-1:0] IRQC_REGION =
        REGION_W'(`PERIPH_IRQC_BASE >> `PERIPH_OFS_W);

    logic [REGION_W-1:0] region;
    bus_target_e         tgt_d;
    bus_target_e         tgt_q;
    logic                req_q;
    bus_op_e             op_q;
    bus_ofs_t            ofs_q;
    bus_data_t           wdata_q;

    // Classify once, before the register
    assign region = req_addr_i[`PERIPH_ADDR_W-1:`PERIPH_OFS_W];

    always_comb begin
        if (region == TIMER_REGION) begin
            tgt_d = TGT_TIMER;
        end else if (region == IRQC_REGION) begin
            tgt_d = TGT_IRQC;
        end else begin
            tgt_d = TGT_ERR;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
            tgt_q <= TGT_ERR;
        end else begin
            req_q <= req_i;
            tgt_q <= tgt_d;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            op_q    <= req_op_i;
            ofs_q   <= req_addr_i[`PERIPH_OFS_W-1:0];
            wdata_q <= req_wdata_i;
        end
    end

    assign tmr_req_o = req_q && (tgt_q == TGT_TIMER);
    assign irq_req_o = req_q && (tgt_q == TGT_IRQC);
    assign err_req_o = req_q && (tgt_q == TGT_ERR);
    assign op_o      = op_q;
    assign ofs_o     = ofs_q;
    assign wdata_o   = wdata_q;

endmodule

/* design/event_timer.sv */
// Compare timers, count runs while CTRL bit 0 is set
// On count == compare the count wraps to zero and a one-cycle irq pulse fires
// A write to count or compare replaces that cycle's increment
// Writes answer with zero read data, unmapped offsets read as zero

`timescale 1ns/10ps

`include "periph_config.svh"

module event_timer (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  periph_bus_pkg::bus_op_e     op_i,
    input  periph_bus_pkg::bus_ofs_t    ofs_i,
    input  periph_bus_pkg::bus_data_t   wdata_i,
    output logic                        rsp_valid_o,
    output periph_bus_pkg::bus_data_t   rdata_o,
    output periph_irq_pkg::timer_irq_t  timer_irq_o
);
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;

    localparam int NUM_TIMERS = `PERIPH_NUM_TIMERS;
    localparam int CHAN_W     = `PERIPH_OFS_W - 4;

    logic [CHAN_W-1:0]     chan_sel;
    timer_reg_e            reg_sel;
    logic [NUM_TIMERS-1:0] wr_ctrl;
    logic [NUM_TIMERS-1:0] wr_count;
    logic [NUM_TIMERS-1:0] wr_compare;

    logic [NUM_TIMERS-1:0] en_q;
    bus_data_t             count_q   [NUM_TIMERS];
    bus_data_t             compare_q [NUM_TIMERS];
    timer_irq_t            irq_q;
    logic                  rsp_valid_q;
    bus_data_t             rdata_d;
    bus_data_t             rdata_q;

    assign chan_sel = ofs_i[`PERIPH_OFS_W-1:4];
    assign reg_sel  = timer_reg_e'(ofs_i[3:0]);

    //////////////////////////////////////////////////////////////////////
    // Register access
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_ctrl    = '0;
        wr_count   = '0;
        wr_compare = '0;
        rdata_d    = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (chan_sel == CHAN_W'(i)) begin
                if (req_i && (op_i == OP_WRITE)) begin
                    wr_ctrl[i]    = (reg_sel == TREG_CTRL);
                    wr_count[i]   = (reg_sel == TREG_COUNT);
                    wr_compare[i] = (reg_sel == TREG_COMPARE);
                end else if (op_i == OP_READ) begin
                    case (reg_sel)
                        TREG_CTRL:    rdata_d = bus_data_t'(en_q[i]);
                        TREG_COUNT:   rdata_d = count_q[i];
                        TREG_COMPARE: rdata_d = compare_q[i];
                        default:      rdata_d = '0;
                    endcase
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q  <= '0;
            irq_q <= '0;
            for (int i = 0; i < NUM_TIMERS; i++) begin
                count_q[i]   <= '0;
                compare_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                irq_q[i] <= 1'b0;
                if (wr_ctrl[i]) begin
                    en_q[i] <= wdata_i[0];
                end
                if (wr_compare[i]) begin
                    compare_q[i] <= wdata_i;
                end
                if (wr_count[i]) begin
                    count_q[i] <= wdata_i;
                end else if (en_q[i] && !wr_compare[i]) begin
                    // Match wraps and pulses
                    if (count_q[i] == compare_q[i]) begin
                        count_q[i] <= '0;
                        irq_q[i]   <= 1'b1;
                    end else begin
                        count_q[i] <= count_q[i] + bus_data_t'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;
    assign timer_irq_o = irq_q;

endmodule

/* design/irq_controller.sv */
// Level sampling interrupt controller with pending and enable registers
// Writing 1 to a pending bit clears it unless its source is high that cycle
// irq_o is combinational from pending and enable, writes return zero data

`timescale 1ns/10ps

`include "periph_config.svh"

module irq_controller (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  periph_bus_pkg::bus_op_e     op_i,
    input  periph_bus_pkg::bus_ofs_t    ofs_i,
    input  periph_bus_pkg::bus_data_t   wdata_i,
    input  periph_irq_pkg::ext_irq_t    ext_irq_i,
    input  periph_irq_pkg::timer_irq_t  timer_irq_i,
    output logic                        rsp_valid_o,
    output periph_bus_pkg::bus_data_t   rdata_o,
    output logic                        irq_o
);
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;

    localparam int NUM_SRC    = `PERIPH_NUM_SRC;
    localparam int NUM_EXT    = `PERIPH_NUM_EXT_IRQ;
    localparam int NUM_TIMERS = `PERIPH_NUM_TIMERS;

    irq_src_vec_t src_vec;
    irq_src_vec_t pending_q;
    irq_src_vec_t enable_q;
    irq_src_vec_t clr_mask;
    irqc_reg_e    reg_sel;
    logic         reg_hit;
    logic         wr_pending;
    logic         wr_enable;
    logic         rsp_valid_q;
    bus_data_t    rdata_d;
    bus_data_t    rdata_q;

    //////////////////////////////////////////////////////////////////////
    // Source map
    //////////////////////////////////////////////////////////////////////

    // Bit 0 and the reserved top bits stay zero
    always_comb begin
        src_vec = '0;
        src_vec[SRC_TIMER0 +: NUM_TIMERS] = timer_irq_i;
        src_vec[SRC_EXT_LO +: NUM_EXT]    = ext_irq_i;
    end

    assign reg_hit    = (ofs_i[`PERIPH_OFS_W-1:4] == '0);
    assign reg_sel    = irqc_reg_e'(ofs_i[3:0]);
    assign wr_pending = req_i && (op_i == OP_WRITE) && reg_hit && (reg_sel == IREG_PENDING);
    assign wr_enable  = req_i && (op_i == OP_WRITE) && reg_hit && (reg_sel == IREG_ENABLE);
    assign clr_mask   = wr_pending ? wdata_i[NUM_SRC-1:0] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            // Set beats clear
            pending_q <= (pending_q & ~clr_mask) | src_vec;
            if (wr_enable) begin
                enable_q <= wdata_i[NUM_SRC-1:0];
            end
        end
    end

    always_comb begin
        rdata_d = '0;
        if (reg_hit && (op_i == OP_READ)) begin
            case (reg_sel)
                IREG_PENDING: rdata_d = bus_data_t'(pending_q);
                IREG_ENABLE:  rdata_d = bus_data_t'(enable_q);
                IREG_RAW:     rdata_d = bus_data_t'(src_vec);
                default:      rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;
    assign irq_o       = |(pending_q & enable_q);

endmodule

/* design/rsp_mux.sv */
// Response stage, at most one response source is valid in any cycle
// Error requests answer with the fixed error pattern and a slave error

`timescale 1ns/10ps

`include "periph_config.svh"

module rsp_mux (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        err_req_i,
    input  logic                        tmr_rsp_valid_i,
    input  periph_bus_pkg::bus_data_t   tmr_rdata_i,
    input  logic                        irq_rsp_valid_i,
    input  periph_bus_pkg::bus_data_t   irq_rdata_i,
    output logic                        rsp_valid_o,
    output periph_bus_pkg::bus_data_t   rsp_rdata_o,
    output periph_bus_pkg::bus_resp_e   rsp_resp_o
);
    import periph_bus_pkg::*;

    localparam bus_data_t ERR_RDATA = `PERIPH_ERR_RDATA;

    logic      err_q;
    logic      rsp_valid_q;
    bus_data_t rsp_rdata_q;
    bus_resp_e rsp_resp_q;

    // Error strobe lines up with the peripheral response stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            err_q       <= err_req_i;
            rsp_valid_q <= err_q || tmr_rsp_valid_i || irq_rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (err_q) begin
            rsp_rdata_q <= ERR_RDATA;
            rsp_resp_q  <= RESP_SLVERR;
        end else if (tmr_rsp_valid_i) begin
            rsp_rdata_q <= tmr_rdata_i;
            rsp_resp_q  <= RESP_OKAY;
        end else if (irq_rsp_valid_i) begin
            rsp_rdata_q <= irq_rdata_i;
            rsp_resp_q  <= RESP_OKAY;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_resp_o  = rsp_resp_q;

endmodule

/* design/periph_subsys_top.sv */
// Timer and interrupt controller behind one register bus
// Every request gets one response exactly 3 cycles after it is sampled

`timescale 1ns/10ps

module periph_subsys_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  periph_bus_pkg::bus_op_e     req_op_i,
    input  periph_bus_pkg::bus_addr_t   req_addr_i,
    input  periph_bus_pkg::bus_data_t   req_wdata_i,
    output logic                        rsp_valid_o,
    output periph_bus_pkg::bus_data_t   rsp_rdata_o,
    output periph_bus_pkg::bus_resp_e   rsp_resp_o,
    input  periph_irq_pkg::ext_irq_t    ext_irq_i,
    output logic                        irq_o
);
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;

    logic       tmr_req;
    logic       irq_req;
    logic       err_req;
    bus_op_e    op;
    bus_ofs_t   ofs;
    bus_data_t  wdata;
    logic       tmr_rsp_valid;
    bus_data_t  tmr_rdata;
    logic       irq_rsp_valid;
    bus_data_t  irq_rdata;
    timer_irq_t timer_irq;

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////
    reg_bus_decoder i_decoder (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_i       ( req_i       ),
        .req_op_i    ( req_op_i    ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .tmr_req_o   ( tmr_req     ),
        .irq_req_o   ( irq_req     ),
        .err_req_o   ( err_req     ),
        .op_o        ( op          ),
        .ofs_o       ( ofs         ),
        .wdata_o     ( wdata       )
    );

    //////////////////////////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////////////////////////
    event_timer i_timer (
        .clk_i       ( clk_i         ),
        .arst_n_i    ( arst_n_i      ),
        .req_i       ( tmr_req       ),
        .op_i        ( op            ),
        .ofs_i       ( ofs           ),
        .wdata_i     ( wdata         ),
        .rsp_valid_o ( tmr_rsp_valid ),
        .rdata_o     ( tmr_rdata     ),
        .timer_irq_o ( timer_irq     )
    );

    irq_controller i_irqc (
        .clk_i       ( clk_i         ),
        .arst_n_i    ( arst_n_i      ),
        .req_i       ( irq_req       ),
        .op_i        ( op            ),
        .ofs_i       ( ofs           ),
        .wdata_i     ( wdata         ),
        .ext_irq_i   ( ext_irq_i     ),
        .timer_irq_i ( timer_irq     ),
        .rsp_valid_o ( irq_rsp_valid ),
        .rdata_o     ( irq_rdata     ),
        .irq_o       ( irq_o         )
    );

    // Response side
    rsp_mux i_rsp_mux (
        .clk_i           ( clk_i         ),
        .arst_n_i        ( arst_n_i      ),
        .err_req_i       ( err_req       ),
        .tmr_rsp_valid_i ( tmr_rsp_valid ),
        .tmr_rdata_i     ( tmr_rdata     ),
        .irq_rsp_valid_i ( irq_rsp_valid ),
        .irq_rdata_i     ( irq_rdata     ),
        .rsp_valid_o     ( rsp_valid_o   ),
        .rsp_rdata_o     ( rsp_rdata_o   ),
        .rsp_resp_o      ( rsp_resp_o    )
    );

endmodule

/* tb/tb_periph_model.svh */
// Reference model of the register map, included inside the testbench module
// Shadows start at reset values, timer counts are zeroed before a channel runs
// Count of an enabled timer and the interrupt bits of running timers are don't care

`ifndef TB_PERIPH_MODEL_SVH
`define TB_PERIPH_MODEL_SVH

logic [31:0] shadow_count   [2];
logic [31:0] shadow_compare [2];
logic [1:0]  shadow_timer_en;
logic [15:0] shadow_enable;
logic [15:0] shadow_pending;
logic [15:0] lfsr_state;

// Expected read data, care mask and response code for one request
function automatic void model_access(input bus_op_e op, input bus_addr_t addr,
                                     input bus_data_t wdata, output bus_data_t rdata,
                                     output bus_data_t mask, output bus_resp_e resp);
    logic [7:0]  chan;
    logic [3:0]  reg_ofs;
    logic [15:0] live;
    bus_data_t   tmr_bits;
    chan     = addr[11:4];
    reg_ofs  = addr[3:0];
    live     = 16'(ext_irq) << SRC_EXT_LO;
    tmr_bits = 32'(shadow_timer_en) << SRC_TIMER0;
    rdata    = '0;
    mask     = '1;
    resp     = RESP_OKAY;
    if (addr[15:12] > 4'd1) begin
        rdata = `PERIPH_ERR_RDATA;
        resp  = RESP_SLVERR;
    end else if (addr[15:12] == 4'd0 && chan < 8'd2) begin
        if (op == OP_WRITE) begin
            case (reg_ofs)
                4'h0:    shadow_timer_en[chan[0]] = wdata[0];
                4'h4:    shadow_count[chan[0]]    = wdata;
                4'h8:    shadow_compare[chan[0]]  = wdata;
                default: ;
            endcase
        end else begin
            case (reg_ofs)
                4'h0:    rdata = 32'(shadow_timer_en[chan[0]]);
                4'h4:    rdata = shadow_count[chan[0]];
                4'h8:    rdata = shadow_compare[chan[0]];
                default: rdata = '0;
            endcase
            // A running count cannot be predicted
            if (reg_ofs == 4'h4 && shadow_timer_en[chan[0]]) begin
                mask = '0;
            end
        end
    end else if (addr[15:12] == 4'd1 && chan == 8'd0) begin
        if (op == OP_WRITE) begin
            if (reg_ofs == 4'h0) begin
                shadow_pending = (shadow_pending & ~wdata[15:0]) | live;
            end else if (reg_ofs == 4'h4) begin
                shadow_enable = wdata[15:0];
            end
        end else begin
            case (reg_ofs)
                4'h0:    rdata = 32'(shadow_pending);
                4'h4:    rdata = 32'(shadow_enable);
                4'h8:    rdata = 32'(live);
                default: rdata = '0;
            endcase
            if (reg_ofs == 4'h0 || reg_ofs == 4'h8) begin
                mask = ~tmr_bits;
            end
        end
    end
endfunction

// External lines seen high latch into pending
function automatic void model_ext(input ext_irq_t lines);
    shadow_pending = shadow_pending | (16'(lines) << SRC_EXT_LO);
endfunction

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
endfunction

function automatic bus_data_t rand_bits(input int n);
    bus_data_t value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_bit()};
    end
    return value;
endfunction

task automatic check_value(input string what, input bus_data_t actual,
                           input bus_data_t expected, input bus_data_t mask);
    if ((actual & mask) !== (expected & mask)) begin
        abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h (mask %h)",
                            $time, what, actual, expected, mask));
    end
endtask

`endif

/* tb/tb_periph_subsys.sv */
// Testbench for periph_subsys_top with inputs driven on the falling clock edge
// Each response is checked in request order exactly 3 cycles after its request
// The run stops at the first error

`timescale 1ns/10ps

`include "periph_config.svh"

module tb_periph_subsys;
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;

    localparam int        RSP_LATENCY  = 3;
    localparam int        WAIT_LIMIT   = 50;
    localparam int        POLL_LIMIT   = 20;
    localparam bus_addr_t IRQC_PENDING = 16'h1000;
    localparam bus_addr_t IRQC_ENABLE  = 16'h1004;
    localparam bus_addr_t IRQC_RAW     = 16'h1008;

    logic      clk;
    logic      arst_n;
    logic      req;
    bus_op_e   req_op;
    bus_addr_t req_addr;
    bus_data_t req_wdata;
    logic      rsp_valid;
    bus_data_t rsp_rdata;
    bus_resp_e rsp_resp;
    ext_irq_t  ext_irq;
    logic      irq;

    // Expected responses filled by the driver and walked by the checker
    bus_data_t exp_rdata_q [$];
    bus_data_t exp_mask_q  [$];
    bus_resp_e exp_resp_q  [$];
    int        exp_due_q   [$];
    int        rsp_idx;
    int        cyc;
    bus_data_t last_rdata;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    `include "tb_periph_model.svh"

    periph_subsys_top dut (
        .clk_i       ( clk       ),
        .arst_n_i    ( arst_n    ),
        .req_i       ( req       ),
        .req_op_i    ( req_op    ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_resp_o  ( rsp_resp  ),
        .ext_irq_i   ( ext_irq   ),
        .irq_o       ( irq       )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response checker
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            if (rsp_idx >= exp_due_q.size()) begin
                abort_run("Response strobe arrived with no request outstanding");
            end else begin
                check_value("response cycle", 32'(cyc), 32'(exp_due_q[rsp_idx]), '1);
                check_value("read data", rsp_rdata, exp_rdata_q[rsp_idx], exp_mask_q[rsp_idx]);
                check_value("response code", 32'(rsp_resp), 32'(exp_resp_q[rsp_idx]), '1);
                last_rdata = rsp_rdata;
                rsp_idx    = rsp_idx + 1;
            end
        end else if (rsp_idx < exp_due_q.size() && exp_due_q[rsp_idx] <= cyc) begin
            abort_run($sformatf("No response to request %0d by cycle %0d", rsp_idx, cyc));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus driver
    //////////////////////////////////////////////////////////////////////

    task automatic issue(input bus_op_e op, input bus_addr_t addr, input bus_data_t wdata);
        bus_data_t e_rdata;
        bus_data_t e_mask;
        bus_resp_e e_resp;
        @(negedge clk);
        req       = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        model_access(op, addr, wdata, e_rdata, e_mask, e_resp);
        exp_rdata_q.push_back(e_rdata);
        exp_mask_q.push_back(e_mask);
        exp_resp_q.push_back(e_resp);
        // Response is due after the third rising edge from here
        exp_due_q.push_back(cyc + RSP_LATENCY);
    endtask

    task automatic wait_responses();
        int waited;
        @(negedge clk);
        req    = 1'b0;
        req_op = OP_READ;
        waited = 0;
        while (rsp_idx < exp_due_q.size() && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rsp_idx < exp_due_q.size()) begin
            abort_run("Timed out waiting for bus responses");
        end
    endtask

    task automatic access(input bus_op_e op, input bus_addr_t addr, input bus_data_t wdata);
        issue(op, addr, wdata);
        wait_responses();
    endtask

    task automatic set_ext(input ext_irq_t lines);
        @(negedge clk);
        ext_irq = lines;
        model_ext(lines);
    endtask

    function automatic bus_op_e rand_op();
        bus_data_t r;
        r = rand_bits(1);
        return r[0] ? OP_WRITE : OP_READ;
    endfunction

    // Registers whose contents the model tracks exactly
    function automatic bus_addr_t shadow_addr(input int k);
        bus_addr_t addr;
        case (k)
            0:       addr = 16'h0004;
            1:       addr = 16'h0008;
            2:       addr = 16'h0014;
            3:       addr = 16'h0018;
            default: addr = IRQC_ENABLE;
        endcase
        return addr;
    endfunction

    task automatic read_back_all();
        for (int k = 0; k < 5; k++) begin
            issue(OP_READ, shadow_addr(k), '0);
        end
        wait_responses();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequences
    //////////////////////////////////////////////////////////////////////

    task automatic exercise_registers();
        bus_data_t r;
        for (int i = 0; i < 32; i++) begin
            r = rand_bits(3);
            issue(rand_op(), shadow_addr(int'(r % 5)), rand_bits(32));
        end
        wait_responses();
        read_back_all();
    endtask

    // Regions 2 to 15 answer with a slave error
    task automatic probe_error_regions();
        bus_data_t r;
        bus_addr_t addr;
        for (int i = 0; i < 16; i++) begin
            // Offsets of live registers so a stray write shows in the read-back
            r    = rand_bits(3);
            addr = shadow_addr(int'(r % 5));
            r    = rand_bits(4);
            if (r < 2) begin
                r = r + 2;
            end
            addr[15:12] = r[3:0];
            issue(rand_op(), addr, rand_bits(32));
        end
        wait_responses();
        read_back_all();
    endtask

    task automatic probe_unmapped_offsets();
        bus_addr_t holes [6];
        holes = '{16'h000C, 16'h0020, 16'h0FF4, 16'h1003, 16'h1010, 16'h1FF0};
        for (int i = 0; i < 6; i++) begin
            issue(OP_WRITE, holes[i], rand_bits(32));
        end
        for (int i = 0; i < 6; i++) begin
            issue(OP_READ, holes[i], '0);
        end
        wait_responses();
        read_back_all();
    endtask

    task automatic ext_line_interrupt();
        bus_data_t r;
        int        line;
        int        src;
        r    = rand_bits(3);
        line = int'(r[2:0]);
        src  = SRC_EXT_LO + line;
        access(OP_WRITE, IRQC_ENABLE, '0);
        set_ext(ext_irq_t'(1) << line);
        repeat (2) @(negedge clk);
        check_value("irq_o with the line masked", 32'(irq), 32'd0, '1);
        access(OP_READ, IRQC_RAW, '0);
        access(OP_READ, IRQC_PENDING, '0);
        set_ext('0);
        access(OP_WRITE, IRQC_ENABLE, 32'(1) << src);
        check_value("irq_o with the line enabled", 32'(irq), 32'd1, '1);
        access(OP_WRITE, IRQC_PENDING, 32'(1) << src);
        check_value("irq_o after pending clear", 32'(irq), 32'd0, '1);
        access(OP_READ, IRQC_PENDING, '0);
    endtask

    task automatic timer_interrupt();
        int polls;
        access(OP_WRITE, 16'h0004, '0);
        access(OP_WRITE, 16'h0008, 32'd20);
        access(OP_WRITE, IRQC_ENABLE, 32'(1) << SRC_TIMER0);
        access(OP_WRITE, 16'h0000, 32'd1);
        polls = 0;
        while (last_rdata[SRC_TIMER0] !== 1'b1 && polls < POLL_LIMIT) begin
            access(OP_READ, IRQC_PENDING, '0);
            polls++;
        end
        if (last_rdata[SRC_TIMER0] !== 1'b1) begin
            abort_run("Timer 0 never set its pending bit");
        end else begin
            check_value("irq_o with timer 0 enabled", 32'(irq), 32'd1, '1);
            // Source 0 and the idle lines must read zero
            access(OP_READ, IRQC_RAW, '0);
        end
    endtask

    initial begin
        arst_n          = 1'b0;
        req             = 1'b0;
        req_op          = OP_READ;
        req_addr        = '0;
        req_wdata       = '0;
        ext_irq         = '0;
        lfsr_state      = 16'd30798;
        shadow_count    = '{32'd0, 32'd0};
        shadow_compare  = '{32'd0, 32'd0};
        shadow_timer_en = '0;
        shadow_enable   = '0;
        shadow_pending  = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        check_value("rsp_valid_o after reset", 32'(rsp_valid), 32'd0, '1);
        check_value("irq_o after reset", 32'(irq), 32'd0, '1);
        exercise_registers();
        probe_error_regions();
        probe_unmapped_offsets();
        ext_line_interrupt();
        timer_interrupt();
        $display("Test passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+design
+incdir+tb
design/periph_bus_pkg.sv
design/periph_irq_pkg.sv
design/reg_bus_decoder.sv
design/event_timer.sv
design/irq_controller.sv
design/rsp_mux.sv
design/periph_subsys_top.sv
tb/tb_periph_subsys.sv

/* Makefile */
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_periph_subsys \
		-f files.f --Mdir $(BUILD_DIR) -o sim_periph
	./$(BUILD_DIR)/sim_periph 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
